// ==== verilog/rf_pkg.sv ====
// Shared widths, register indices and APB register map for the register-file subsystem

package rf_pkg;

    ////////////////////
    // Datapath sizes
    ////////////////////

    localparam int XLEN      = 32;           // Register width
    localparam int WAYS      = 2;            // Issue / retire width
    localparam int REG_IDX_W = 5;            // Architectural index bits
    localparam int NUM_REGS  = 2**REG_IDX_W; // x0 .. x31

    typedef logic [XLEN-1:0]      data_t;     // One register value
    typedef logic [REG_IDX_W-1:0] reg_idx_t;  // Architectural register number
    typedef logic [7:0]           apb_addr_t; // Host port byte address

    // Hard-wired zero register
    localparam reg_idx_t ZERO_REG = '0;

    ////////////////////
    // APB register map
    ////////////////////

    // Bit 0 freezes writeback
    localparam apb_addr_t ADDR_CTRL     = 8'h00;
    // Register selected for debug access
    localparam apb_addr_t ADDR_DBG_IDX  = 8'h04;
    // Read returns selected register, write stores into it
    localparam apb_addr_t ADDR_DBG_DATA = 8'h08;
    // Retired-write count, read only
    localparam apb_addr_t ADDR_WB_COUNT = 8'h0C;

endpackage

// ==== verilog/regfile.sv ====
// Architectural register file with four operand reads, a debug read and two forwarded writes

module regfile (
    input  logic                                 wr_clk,
    input  logic                                 rst,
    // Operand read ports, one index per way
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_1,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_2,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_1,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_2,
    // Write ports from writeback
    input  logic             [rf_pkg::WAYS-1:0] rf_we,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rf_widx,
    input  rf_pkg::data_t    [rf_pkg::WAYS-1:0] rf_wdata,
    // Host debug read
    input  rf_pkg::reg_idx_t                    dbg_idx,
    output rf_pkg::data_t                       dbg_rdata
);

    // x0 has no storage
    rf_pkg::data_t [rf_pkg::NUM_REGS-1:1] registers;

    ////////////////////
    // Read side
    ////////////////////

    // One read port: zero for x0, then way 1 bypass, way 0 bypass, storage
    function automatic rf_pkg::data_t read_port(input rf_pkg::reg_idx_t idx);
        rf_pkg::data_t val;
        if (idx == rf_pkg::ZERO_REG) begin
            val = '0;
        end else if (rf_we[1] && (rf_widx[1] == idx)) begin
            val = rf_wdata[1];                 // Younger write wins
        end else if (rf_we[0] && (rf_widx[0] == idx)) begin
            val = rf_wdata[0];
        end else begin
            val = registers[idx];
        end
        return val;
    endfunction

    always_comb begin
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            rd_data_1[w] = read_port(rd_idx_1[w]); // rs1 of way w
            rd_data_2[w] = read_port(rd_idx_2[w]); // rs2 of way w
        end
    end

    // Debug view also sees writes landing this cycle
    always_comb begin
        dbg_rdata = read_port(dbg_idx);
    end

    ////////////////////
    // Write side
    ////////////////////

    // Ways visited in program order, so way 1 overrides way 0 on a collision
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            registers <= '0;
        end else begin
            for (int w = 0; w < rf_pkg::WAYS; w++) begin
                if (rf_we[w] && (rf_widx[w] != rf_pkg::ZERO_REG)) begin
                    registers[rf_widx[w]] <= rf_wdata[w]; // x0 writes dropped
                end
            end
        end
    end

endmodule

// ==== verilog/operand_fetch.sv ====
// ID-stage pipeline register that reads both instructions' source operands under valid/ready

module operand_fetch (
    input  logic                                 wr_clk,
    input  logic                                 rst,
    // From decode
    input  logic                                 id_valid,
    output logic                                 id_ready,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs1,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs2,
    // Register file read ports
    output rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_1,
    output rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_2,
    input  rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_1,
    input  rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_2,
    // To execute
    output logic                                 op_valid,
    input  logic                                 op_ready,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs1_data,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs2_data
);

    logic id_fire; // Bundle accepted this edge

    // Stage can take a new bundle when empty or being drained
    assign id_ready = !op_valid || op_ready;
    assign id_fire  = id_valid && id_ready;

    // Indices go straight to the register file, reads are combinational
    assign rd_idx_1 = id_rs1;
    assign rd_idx_2 = id_rs2;

    ////////////////////
    // Valid flag
    ////////////////////

    always_ff @(posedge wr_clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (id_fire) begin
            op_valid <= 1'b1;       // New bundle replaces or fills
        end else if (op_ready) begin
            op_valid <= 1'b0;       // Consumer took the last one
        end
    end

    // Operand payload
    // Captured only on acceptance so it holds under back-pressure
    always_ff @(posedge wr_clk) begin
        if (id_fire) begin
            op_rs1_data <= rd_data_1; // Includes same-edge forwarding
            op_rs2_data <= rd_data_2;
        end
    end

endmodule

// ==== verilog/wb_port.sv ====
// Writeback stage forming register-file writes from completions and host debug writes

module wb_port (
    input  logic                                 wr_clk,
    input  logic                                 rst,
    // Completions, one per way
    input  logic             [rf_pkg::WAYS-1:0] wb_valid,
    output logic                                 wb_ready,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] wb_idx,
    input  rf_pkg::data_t    [rf_pkg::WAYS-1:0] wb_data,
    // Host control
    input  logic                                 freeze,
    input  logic                                 dbg_wr_req,
    input  rf_pkg::reg_idx_t                    dbg_idx,
    input  rf_pkg::data_t                       dbg_wdata,
    output logic                                 dbg_wr_done,
    // Register file write ports
    output logic             [rf_pkg::WAYS-1:0] rf_we,
    output rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rf_widx,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] rf_wdata,
    // Retired writes to x1..x31
    output rf_pkg::data_t                       wb_count
);

    logic [rf_pkg::WAYS-1:0]                wb_take;    // Accepted this edge
    logic [rf_pkg::WAYS-1:0]                retire;     // Accepted and not x0
    logic [$clog2(rf_pkg::WAYS + 1)-1:0]    retire_num;

    // Stall completions while frozen or while the host owns port 0
    assign wb_ready    = !freeze && !dbg_wr_req;
    // Debug write lands at the edge ending this cycle
    assign dbg_wr_done = dbg_wr_req;

    always_comb begin
        retire_num = '0;
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            wb_take[w] = wb_valid[w] && wb_ready;
            retire[w]  = wb_take[w] && (wb_idx[w] != rf_pkg::ZERO_REG);
            retire_num = retire_num + retire[w];
        end
    end

    ////////////////////
    // Write port steering
    ////////////////////

    always_comb begin
        rf_we    = wb_take;
        rf_widx  = wb_idx;
        rf_wdata = wb_data;
        if (dbg_wr_req) begin
            // Host write borrows port 0 for one cycle
            rf_we[0]    = 1'b1;
            rf_widx[0]  = dbg_idx;
            rf_wdata[0] = dbg_wdata;
        end
    end

    // Retired write counter
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            wb_count <= '0;
        end else begin
            wb_count <= wb_count + rf_pkg::data_t'(retire_num); // 0, 1 or 2 per edge
        end
    end

endmodule

// ==== verilog/rf_debug_apb.sv ====
// APB slave for freezing writeback, host register access and the retired-write count

module rf_debug_apb (
    input  logic                  wr_clk,
    input  logic                  rst,
    // APB slave
    input  rf_pkg::apb_addr_t    paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  rf_pkg::data_t        pwdata,
    output rf_pkg::data_t        prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Register file debug access
    input  rf_pkg::data_t        dbg_rdata,
    output rf_pkg::reg_idx_t     dbg_idx,
    output rf_pkg::data_t        dbg_wdata,
    output logic                  dbg_wr_req,
    input  logic                  dbg_wr_done,
    // Writeback control and status
    output logic                  freeze,
    input  rf_pkg::data_t        wb_count
);

    logic apb_setup;    // First cycle of a transfer
    logic apb_done;     // Access cycle with pready high
    logic addr_hit;     // paddr is in the map
    logic addr_err;     // Unmapped, or write to read-only count
    logic dbg_data_wr;  // Write to DBG_DATA, takes one wait state

    assign apb_setup = psel && !penable;
    assign apb_done  = psel && penable && pready;

    ////////////////////
    // Address decode
    ////////////////////

    always_comb begin
        case (paddr)
            rf_pkg::ADDR_CTRL,
            rf_pkg::ADDR_DBG_IDX,
            rf_pkg::ADDR_DBG_DATA,
            rf_pkg::ADDR_WB_COUNT: addr_hit = 1'b1;
            default:               addr_hit = 1'b0;
        endcase
    end

    assign addr_err    = !addr_hit || (pwrite && (paddr == rf_pkg::ADDR_WB_COUNT));
    assign dbg_data_wr = pwrite && (paddr == rf_pkg::ADDR_DBG_DATA);

    // Read mux, valid during the access cycle
    always_comb begin
        case (paddr)
            rf_pkg::ADDR_CTRL:     prdata = rf_pkg::data_t'(freeze);
            rf_pkg::ADDR_DBG_IDX:  prdata = rf_pkg::data_t'(dbg_idx);
            rf_pkg::ADDR_DBG_DATA: prdata = dbg_rdata;  // Live register view
            rf_pkg::ADDR_WB_COUNT: prdata = wb_count;
            default:               prdata = '0;
        endcase
    end

    ////////////////////
    // Handshake and control
    ////////////////////

    // pready is registered at the end of setup, so plain transfers have no wait state
    always_ff @(posedge wr_clk) begin
        if (rst) begin
            pready     <= 1'b0;
            pslverr    <= 1'b0;
            dbg_wr_req <= 1'b0;
            freeze     <= 1'b0;
            dbg_idx    <= '0;
        end else begin
            pready  <= 1'b0;            // One-cycle strobe by default
            pslverr <= 1'b0;
            if (apb_setup) begin
                if (dbg_data_wr) begin
                    dbg_wr_req <= 1'b1; // Hold pready low until writeback takes it
                end else begin
                    pready  <= 1'b1;
                    pslverr <= addr_err;
                end
            end
            if (dbg_wr_req && dbg_wr_done) begin
                dbg_wr_req <= 1'b0;
                pready     <= 1'b1;     // Completes after exactly one wait state
            end
            // Control writes take effect as the transfer completes
            if (apb_done && pwrite) begin
                if (paddr == rf_pkg::ADDR_CTRL) begin
                    freeze <= pwdata[0];
                end
                if (paddr == rf_pkg::ADDR_DBG_IDX) begin
                    dbg_idx <= rf_pkg::reg_idx_t'(pwdata); // Low index bits only
                end
            end
        end
    end

    // Debug write data, latched with the request
    always_ff @(posedge wr_clk) begin
        if (apb_setup && dbg_data_wr) begin
            dbg_wdata <= pwdata;
        end
    end

endmodule

// ==== verilog/rf_subsys.sv ====
// Top level of the register-file subsystem tying operand fetch, writeback, storage and APB together

module rf_subsys (
    input  logic                                 wr_clk,
    input  logic                                 rst,
    // Operand fetch
    input  logic                                 id_valid,
    output logic                                 id_ready,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs1,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs2,
    output logic                                 op_valid,
    input  logic                                 op_ready,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs1_data,
    output rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs2_data,
    // Writeback
    input  logic             [rf_pkg::WAYS-1:0] wb_valid,
    output logic                                 wb_ready,
    input  rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] wb_idx,
    input  rf_pkg::data_t    [rf_pkg::WAYS-1:0] wb_data,
    // APB host port
    input  rf_pkg::apb_addr_t                   paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  rf_pkg::data_t                       pwdata,
    output rf_pkg::data_t                       prdata,
    output logic                                 pready,
    output logic                                 pslverr
);

    ////////////////////
    // Internal nets
    ////////////////////

    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_1;
    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_2;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_1;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_2;
    logic             [rf_pkg::WAYS-1:0] rf_we;     // Write bus into storage
    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rf_widx;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] rf_wdata;
    rf_pkg::reg_idx_t                    dbg_idx;   // Host debug path
    rf_pkg::data_t                       dbg_rdata;
    rf_pkg::data_t                       dbg_wdata;
    logic                                 dbg_wr_req;
    logic                                 dbg_wr_done;
    logic                                 freeze;
    rf_pkg::data_t                       wb_count;

    regfile u_regfile (
        .wr_clk    (wr_clk),
        .rst       (rst),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .rf_we     (rf_we),
        .rf_widx   (rf_widx),
        .rf_wdata  (rf_wdata),
        .dbg_idx   (dbg_idx),
        .dbg_rdata (dbg_rdata)
    );

    operand_fetch u_operand_fetch (
        .wr_clk      (wr_clk),
        .rst         (rst),
        .id_valid    (id_valid),
        .id_ready    (id_ready),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .rd_idx_1    (rd_idx_1),
        .rd_idx_2    (rd_idx_2),
        .rd_data_1   (rd_data_1),
        .rd_data_2   (rd_data_2),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op_rs1_data (op_rs1_data),
        .op_rs2_data (op_rs2_data)
    );

    wb_port u_wb_port (
        .wr_clk      (wr_clk),
        .rst         (rst),
        .wb_valid    (wb_valid),
        .wb_ready    (wb_ready),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .freeze      (freeze),
        .dbg_wr_req  (dbg_wr_req),
        .dbg_idx     (dbg_idx),
        .dbg_wdata   (dbg_wdata),
        .dbg_wr_done (dbg_wr_done),
        .rf_we       (rf_we),
        .rf_widx     (rf_widx),
        .rf_wdata    (rf_wdata),
        .wb_count    (wb_count)
    );

    rf_debug_apb u_rf_debug_apb (
        .wr_clk      (wr_clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .dbg_rdata   (dbg_rdata),
        .dbg_idx     (dbg_idx),
        .dbg_wdata   (dbg_wdata),
        .dbg_wr_req  (dbg_wr_req),
        .dbg_wr_done (dbg_wr_done),
        .freeze      (freeze),
        .wb_count    (wb_count)
    );

endmodule

// ==== tests/rf_asserts.sv ====
// Concurrent checks on register-file reads, writeback freeze and the APB handshake, bound into the top

module rf_asserts (
    input logic                                 wr_clk,
    input logic                                 rst,
    input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_1,
    input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rd_idx_2,
    input rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_1,
    input rf_pkg::data_t    [rf_pkg::WAYS-1:0] rd_data_2,
    input logic             [rf_pkg::WAYS-1:0] rf_we,
    input logic                                 psel,
    input logic                                 pready,
    input logic                                 freeze,
    input logic                                 wb_ready
);

    logic x0_clean; // No port reading x0 sees a nonzero value

    always_comb begin
        x0_clean = 1'b1;
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            if (rd_idx_1[w] == rf_pkg::ZERO_REG && rd_data_1[w] != '0) begin
                x0_clean = 1'b0;
            end
            if (rd_idx_2[w] == rf_pkg::ZERO_REG && rd_data_2[w] != '0) begin
                x0_clean = 1'b0;
            end
        end
    end

    x0_after_write: assert property (@(posedge wr_clk) disable iff (rst)
        (|rf_we) |=> x0_clean)
        else $error("x0 read back nonzero after a write");

    pready_needs_psel: assert property (@(posedge wr_clk) disable iff (rst)
        $rose(pready) |-> psel)
        else $error("pready rose with psel low");

    freeze_stalls_wb: assert property (@(posedge wr_clk) disable iff (rst)
        freeze |-> !wb_ready)
        else $error("wb_ready high while writeback frozen");

endmodule

// ==== tests/tb_rf_subsys.sv ====
// Directed testbench for the register-file subsystem, run as the simulation top with the file list

module tb_rf_subsys;

    localparam int CLK_PERIOD  = 40;
    localparam int HS_LIMIT    = 16;   // Cycles before a handshake counts as stuck
    localparam int TEST_CYCLES = 200;  // Rough length of all tests together
    localparam int MARGIN      = 100;

    logic                                 wr_clk;
    logic                                 rst;
    logic                                 id_valid;
    logic                                 id_ready;
    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs1;
    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] id_rs2;
    logic                                 op_valid;
    logic                                 op_ready;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs1_data;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] op_rs2_data;
    logic             [rf_pkg::WAYS-1:0] wb_valid;
    logic                                 wb_ready;
    rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] wb_idx;
    rf_pkg::data_t    [rf_pkg::WAYS-1:0] wb_data;
    rf_pkg::apb_addr_t                   paddr;
    logic                                 psel;
    logic                                 penable;
    logic                                 pwrite;
    rf_pkg::data_t                       pwdata;
    rf_pkg::data_t                       prdata;
    logic                                 pready;
    logic                                 pslverr;

    integer seed;
    int     checks;
    int     errors;
    string  cur_test;

    rf_pkg::data_t model_regs [rf_pkg::NUM_REGS]; // Architectural state
    logic [31:0]   model_count;                   // Retired writes to x1..x31

    rf_subsys uut (.*);

    bind rf_subsys rf_asserts u_rf_asserts (
        .wr_clk    (wr_clk),
        .rst       (rst),
        .rd_idx_1  (rd_idx_1),
        .rd_idx_2  (rd_idx_2),
        .rd_data_1 (rd_data_1),
        .rd_data_2 (rd_data_2),
        .rf_we     (rf_we),
        .psel      (psel),
        .pready    (pready),
        .freeze    (freeze),
        .wb_ready  (wb_ready)
    );

    initial begin
        wr_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wr_clk = ~wr_clk;
    end

    // Watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // Checks and model
    ////////////////////

    task automatic check_data(input string what, input rf_pkg::data_t exp,
                              input rf_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED [%s] %s: expected %08h, actual %08h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic report_stuck(input string what);
        errors++;
        $display("[%s] %s stayed low for %0d cycles", cur_test, what, HS_LIMIT);
    endtask

    task automatic finish_test(input int start_err);
        $display("[%s] finished, %0d error(s)", cur_test, errors - start_err);
    endtask

    // x0 is hard-wired, everything else comes from the array
    function automatic rf_pkg::data_t model_read(input rf_pkg::reg_idx_t idx);
        if (idx == rf_pkg::ZERO_REG) begin
            return '0;
        end
        return model_regs[idx];
    endfunction

    // Program order, so way 1 lands last
    task automatic model_retire(input logic [rf_pkg::WAYS-1:0] valid,
                                input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] idx,
                                input rf_pkg::data_t [rf_pkg::WAYS-1:0] data);
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            if (valid[w] && idx[w] != rf_pkg::ZERO_REG) begin
                model_regs[idx[w]] = data[w];
                model_count++;
            end
        end
    endtask

    task automatic check_ops(input rf_pkg::data_t [rf_pkg::WAYS-1:0] exp1,
                             input rf_pkg::data_t [rf_pkg::WAYS-1:0] exp2);
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            check_data($sformatf("op_rs1_data[%0d]", w), exp1[w], op_rs1_data[w]);
            check_data($sformatf("op_rs2_data[%0d]", w), exp2[w], op_rs2_data[w]);
        end
    endtask

    ////////////////////
    // Bus drivers
    ////////////////////

    task automatic writeback(input logic [rf_pkg::WAYS-1:0] valid,
                             input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] idx,
                             input rf_pkg::data_t [rf_pkg::WAYS-1:0] data);
        int n;
        @(negedge wr_clk);
        wb_valid = valid;
        wb_idx   = idx;
        wb_data  = data;
        n = 0;
        while (!wb_ready && n < HS_LIMIT) begin
            @(negedge wr_clk);
            n++;
        end
        if (!wb_ready) begin
            report_stuck("wb_ready");
        end else begin
            model_retire(valid, idx, data); // Accepted at the coming edge
        end
        @(negedge wr_clk);
        wb_valid = '0;
    endtask

    // Operand fetch, optionally with a writeback on the same edge
    task automatic fetch(input logic [rf_pkg::WAYS-1:0] wb_v,
                         input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] wb_i,
                         input rf_pkg::data_t [rf_pkg::WAYS-1:0] wb_d,
                         input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rs1,
                         input rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] rs2);
        rf_pkg::data_t [rf_pkg::WAYS-1:0] exp1;
        rf_pkg::data_t [rf_pkg::WAYS-1:0] exp2;
        int n;
        @(negedge wr_clk);
        wb_valid = wb_v;
        wb_idx   = wb_i;
        wb_data  = wb_d;
        id_valid = 1'b1;
        id_rs1   = rs1;
        id_rs2   = rs2;
        n = 0;
        while (!(id_ready && (wb_ready || wb_v == '0)) && n < HS_LIMIT) begin
            @(negedge wr_clk);
            n++;
        end
        if (n == HS_LIMIT) begin
            report_stuck("id_ready or wb_ready");
        end else begin
            model_retire(wb_v, wb_i, wb_d); // Same-edge writes must be forwarded
        end
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            exp1[w] = model_read(rs1[w]);
            exp2[w] = model_read(rs2[w]);
        end
        @(negedge wr_clk);
        id_valid = 1'b0;
        wb_valid = '0;
        check_bit("op_valid", 1'b1, op_valid);
        check_ops(exp1, exp2);
    endtask

    // Two-phase APB transfer, waits counts access cycles with pready low
    task automatic apb_xfer(input rf_pkg::apb_addr_t addr, input logic write,
                            input rf_pkg::data_t wdata, output rf_pkg::data_t rdata,
                            output logic err, output int waits);
        @(negedge wr_clk);
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge wr_clk);
        penable = 1'b1;
        waits   = 0;
        while (!pready && waits < HS_LIMIT) begin
            @(negedge wr_clk);
            waits++;
        end
        if (!pready) begin
            report_stuck("pready");
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge wr_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // All 32 registers through the four operand ports
    task automatic sweep_regs();
        for (int r = 0; r < rf_pkg::NUM_REGS; r += 4) begin
            fetch('0, '0, '0,
                  {rf_pkg::reg_idx_t'(r + 1), rf_pkg::reg_idx_t'(r)},
                  {rf_pkg::reg_idx_t'(r + 3), rf_pkg::reg_idx_t'(r + 2)});
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_x0();
        rf_pkg::data_t rd;
        logic          err;
        int            waits;
        int            start_err;
        cur_test  = "reset_x0";
        start_err = errors;
        sweep_regs();                                          // Storage cleared by reset
        writeback(2'b11, {rf_pkg::ZERO_REG, rf_pkg::ZERO_REG},
                  {rf_pkg::data_t'($random(seed)), rf_pkg::data_t'($random(seed))});
        fetch('0, '0, '0, '0, '0);                              // x0 on all four ports
        apb_xfer(rf_pkg::ADDR_WB_COUNT, 1'b0, '0, rd, err, waits);
        check_count("wb_count", model_count, rd);               // x0 writes not counted
        finish_test(start_err);
    endtask

    task automatic test_random_wb();
        logic [rf_pkg::WAYS-1:0]             v;
        rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] i;
        rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] r1;
        rf_pkg::reg_idx_t [rf_pkg::WAYS-1:0] r2;
        int                                  start_err;
        cur_test  = "random_wb";
        start_err = errors;
        for (int n = 0; n < 12; n++) begin
            v  = 2'($random(seed));
            i  = 10'($random(seed));
            r1 = 10'($random(seed));
            r2 = 10'($random(seed));
            writeback(v, i, {rf_pkg::data_t'($random(seed)), rf_pkg::data_t'($random(seed))});
            fetch('0, '0, '0, r1, r2);
        end
        sweep_regs();
        finish_test(start_err);
    endtask

    task automatic test_forwarding();
        rf_pkg::reg_idx_t a;
        rf_pkg::reg_idx_t b;
        rf_pkg::data_t    d0;
        rf_pkg::data_t    d1;
        int               start_err;
        cur_test  = "forwarding";
        start_err = errors;
        a  = rf_pkg::reg_idx_t'($random(seed)) | 5'd1;          // Never x0
        b  = rf_pkg::reg_idx_t'($random(seed)) | 5'd2;
        d0 = $random(seed);
        d1 = $random(seed);
        // Way 0 write to a, fetched on the same edge
        fetch(2'b01, {rf_pkg::ZERO_REG, a}, {32'h0, d0}, {a, a}, {a, rf_pkg::ZERO_REG});
        // Both ways hit b, way 1 data expected
        fetch(2'b11, {b, b}, {d1, d0}, {b, a}, {a, b});
        fetch('0, '0, '0, {b, b}, {b, b});                      // Still way 1 afterwards
        finish_test(start_err);
    endtask

    task automatic test_backpressure();
        rf_pkg::data_t [rf_pkg::WAYS-1:0] exp1;
        rf_pkg::data_t [rf_pkg::WAYS-1:0] exp2;
        rf_pkg::data_t [rf_pkg::WAYS-1:0] nxt1;
        rf_pkg::data_t [rf_pkg::WAYS-1:0] nxt2;
        int                               start_err;
        cur_test  = "backpressure";
        start_err = errors;
        @(negedge wr_clk);
        op_ready = 1'b0;
        id_valid = 1'b1;
        id_rs1   = 10'($random(seed));
        id_rs2   = 10'($random(seed));
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            exp1[w] = model_read(id_rs1[w]);
            exp2[w] = model_read(id_rs2[w]);
        end
        for (int n = 0; n < 3; n++) begin
            @(negedge wr_clk);
            id_rs1 = 10'($random(seed));                        // New bundles offered
            id_rs2 = 10'($random(seed));
            check_bit("op_valid held", 1'b1, op_valid);
            check_bit("id_ready stalled", 1'b0, id_ready);
            check_ops(exp1, exp2);
        end
        @(negedge wr_clk);
        op_ready = 1'b1;                                        // Release held bundle
        for (int w = 0; w < rf_pkg::WAYS; w++) begin
            nxt1[w] = model_read(id_rs1[w]);
            nxt2[w] = model_read(id_rs2[w]);
        end
        check_ops(exp1, exp2);                                  // Old bundle consumed first
        @(negedge wr_clk);
        id_valid = 1'b0;
        check_bit("op_valid next", 1'b1, op_valid);
        check_ops(nxt1, nxt2);
        @(negedge wr_clk);
        check_bit("op_valid drained", 1'b0, op_valid);
        finish_test(start_err);
    endtask

    task automatic test_apb();
        rf_pkg::data_t    rd;
        rf_pkg::data_t    v;
        rf_pkg::reg_idx_t k;
        logic             err;
        int               waits;
        int               start_err;
        cur_test  = "apb";
        start_err = errors;
        apb_xfer(rf_pkg::ADDR_CTRL, 1'b1, 32'h1, rd, err, waits);
        check_bit("ctrl write pslverr", 1'b0, err);
        check_count("ctrl write wait states", 0, waits);
        check_bit("wb_ready frozen", 1'b0, wb_ready);
        apb_xfer(rf_pkg::ADDR_CTRL, 1'b0, '0, rd, err, waits);
        check_data("ctrl read", 32'h1, rd);
        apb_xfer(rf_pkg::ADDR_CTRL, 1'b1, '0, rd, err, waits);
        check_bit("wb_ready unfrozen", 1'b1, wb_ready);
        // Host write through the index/data pair
        k = rf_pkg::reg_idx_t'($random(seed)) | 5'd1;
        v = $random(seed);
        apb_xfer(rf_pkg::ADDR_DBG_IDX, 1'b1, rf_pkg::data_t'(k), rd, err, waits);
        apb_xfer(rf_pkg::ADDR_DBG_DATA, 1'b1, v, rd, err, waits);
        check_count("dbg write wait states", 1, waits);
        model_regs[k] = v;                                      // Not a retired writeback
        apb_xfer(rf_pkg::ADDR_DBG_IDX, 1'b0, '0, rd, err, waits);
        check_data("dbg_idx read", rf_pkg::data_t'(k), rd);
        apb_xfer(rf_pkg::ADDR_DBG_DATA, 1'b0, '0, rd, err, waits);
        check_data("dbg_data read", model_read(k), rd);
        fetch('0, '0, '0, {k, k}, {k, k});
        apb_xfer(rf_pkg::ADDR_WB_COUNT, 1'b0, '0, rd, err, waits);
        check_count("wb_count", model_count, rd);
        // Error responses
        apb_xfer(8'h10, 1'b0, '0, rd, err, waits);
        check_bit("unmapped pslverr", 1'b1, err);
        apb_xfer(rf_pkg::ADDR_WB_COUNT, 1'b1, 32'h5, rd, err, waits);
        check_bit("wb_count write pslverr", 1'b1, err);
        finish_test(start_err);
    endtask

    initial begin
        seed        = 32'h867c_8ded;
        checks      = 0;
        errors      = 0;
        model_count = '0;
        for (int r = 0; r < rf_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        rst      = 1'b1;
        id_valid = 1'b0;
        id_rs1   = '0;
        id_rs2   = '0;
        op_ready = 1'b1;                                        // Consumer always ready by default
        wb_valid = '0;
        wb_idx   = '0;
        wb_data  = '0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        repeat (3) @(posedge wr_clk);
        @(negedge wr_clk);
        rst = 1'b0;
        test_reset_x0();
        test_random_wb();
        test_forwarding();
        test_backpressure();
        test_apb();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/rf_pkg.sv
verilog/regfile.sv
verilog/operand_fetch.sv
verilog/wb_port.sv
verilog/rf_debug_apb.sv
verilog/rf_subsys.sv
tests/rf_asserts.sv
tests/tb_rf_subsys.sv

// ==== Bender.yml ====
package:
  name: rf_subsys

sources:
  - verilog/rf_pkg.sv
  - verilog/regfile.sv
  - verilog/operand_fetch.sv
  - verilog/wb_port.sv
  - verilog/rf_debug_apb.sv
  - verilog/rf_subsys.sv
  - target: test
    files:
      - tests/rf_asserts.sv
      - tests/tb_rf_subsys.sv
